//--- source/field_store_macros.svh
// sizes of the field store memory and the command fields, included by the package and all RTL
`ifndef FIELD_STORE_MACROS_SVH
`define FIELD_STORE_MACROS_SVH

`default_nettype none

// one memory word, fields are cut off above its top bit
`define FS_WORD_WIDTH 32

// number of words in the store and the bits needed to address them
`define FS_DEPTH 16
`define FS_ADDR_WIDTH 4

// lowest bit of a field, a value from 0 to 31
`define FS_OFFSET_WIDTH 5

// field length minus one, so a length of 1 to 32 bits fits in 5 bits
`define FS_LEN_WIDTH 5

`default_nettype wire

`endif

//--- source/field_store_pkg.sv
// command and port types shared by the field store decoder, RAM, read unit and testbench
`include "field_store_macros.svh"
`default_nettype none

package field_store_pkg;

   // the op bit sits at the top of both command views and selects the valid one
   typedef enum logic
   {
      FS_OP_READ  = 1'b0,
      FS_OP_WRITE = 1'b1
   } fs_op_e;

   // write view, the value is right-aligned and gets moved up to the offset
   typedef struct packed
   {
      fs_op_e                      op;
      logic [`FS_ADDR_WIDTH-1:0]   addr;
      logic [`FS_OFFSET_WIDTH-1:0] offset;
      logic [`FS_LEN_WIDTH-1:0]    len_m1;
      logic [`FS_WORD_WIDTH-1:0]   value;
   } fs_write_view_t;

   // read view, same layout up front and the low word carries nothing
   typedef struct packed
   {
      fs_op_e                      op;
      logic [`FS_ADDR_WIDTH-1:0]   addr;
      logic [`FS_OFFSET_WIDTH-1:0] offset;
      logic [`FS_LEN_WIDTH-1:0]    len_m1;
      logic [`FS_WORD_WIDTH-1:0]   unused_bits;
   } fs_read_view_t;

   // one 47-bit command word seen either way
   typedef union packed
   {
      fs_write_view_t wr;
      fs_read_view_t  rd;
   } fs_cmd_u;

   // RAM write port, only bits set in mask are written
   typedef struct packed
   {
      logic                        w_v;
      logic [`FS_ADDR_WIDTH-1:0]   addr;
      logic [`FS_WORD_WIDTH-1:0]   mask;
      logic [`FS_WORD_WIDTH-1:0]   data;
   } fs_wr_port_t;

   // read request handed from the decoder to the read unit
   typedef struct packed
   {
      logic                        v;
      logic [`FS_ADDR_WIDTH-1:0]   addr;
      logic [`FS_OFFSET_WIDTH-1:0] offset;
      logic [`FS_LEN_WIDTH-1:0]    len_m1;
   } fs_rd_req_t;

   // RAM read port
   typedef struct packed
   {
      logic                        r_v;
      logic [`FS_ADDR_WIDTH-1:0]   addr;
   } fs_ram_rd_t;

endpackage

`default_nettype wire

//--- source/field_cmd_decoder.sv
// command decoder of the field store, turns field writes into masked RAM writes and reads into requests
`timescale 1ns/1ns
`include "field_store_macros.svh"
`default_nettype none

module field_cmd_decoder
   import field_store_pkg::*;
(
   input  wire logic        clk_i,
   input  wire logic        reset_i,
   input  wire logic        cmd_v_i,
   input  wire fs_cmd_u     cmd_i,
   output      fs_wr_port_t wr_o,
   output      fs_rd_req_t  rd_req_o
);

   // len_m1+1 low ones of the write field, before it is moved up to the offset
   logic [`FS_WORD_WIDTH-1:0] field_ones;
   logic                      is_write;

   // both views keep op in the same place, so either one would do here
   assign is_write = (cmd_i.wr.op == FS_OP_WRITE);

   // shifting an all-ones word down by 31-len_m1 leaves exactly len_m1+1 ones
   assign field_ones = {`FS_WORD_WIDTH{1'b1}}
                       >> (`FS_LEN_WIDTH'(`FS_WORD_WIDTH - 1) - cmd_i.wr.len_m1);

   // write port, decoded through the write view
   always_comb
   begin
      wr_o.w_v  = cmd_v_i && is_write;
      wr_o.addr = cmd_i.wr.addr;
      // the left shift drops every mask and data bit that would land past bit 31
      wr_o.mask = field_ones << cmd_i.wr.offset;
      wr_o.data = cmd_i.wr.value << cmd_i.wr.offset;
   end

   // read request, decoded through the read view
   always_comb
   begin
      rd_req_o.v      = cmd_v_i && !is_write;
      rd_req_o.addr   = cmd_i.rd.addr;
      rd_req_o.offset = cmd_i.rd.offset;
      rd_req_o.len_m1 = cmd_i.rd.len_m1;
   end

   // the RAM has no collision handling, so the two ports must never fire together
   assert property (@(posedge clk_i) disable iff (reset_i)
                    !(wr_o.w_v && rd_req_o.v))
   else
      $error("write and read request in the same cycle");

   // a field always covers at least its offset bit, so an empty mask means a bad decode
   assert property (@(posedge clk_i) disable iff (reset_i)
                    wr_o.w_v |-> (wr_o.mask != '0))
   else
      $error("write with empty mask at address %0h", wr_o.addr);

endmodule

`default_nettype wire

//--- source/field_store_ram.sv
// one-read one-write synchronous RAM of the field store with per-bit write enables
`timescale 1ns/1ns
`include "field_store_macros.svh"
`default_nettype none

module field_store_ram
   import field_store_pkg::*;
(
   input  wire logic                      clk_i,
   input  wire logic                      reset_i,
   input  wire fs_wr_port_t               wr_i,
   input  wire fs_ram_rd_t                rd_i,
   output      logic [`FS_WORD_WIDTH-1:0] r_data_o
);

   // storage has no reset, contents are undefined until a word is written
   logic [`FS_WORD_WIDTH-1:0] mem [`FS_DEPTH];

   // read address captured at the clock edge
   logic [`FS_ADDR_WIDTH-1:0] r_addr_r;

   // the array behaves like a bank of registers
   // the write lands on the clock edge and the read mux works on the
   // latched address after the edge, so a read latched at the next edge
   // already sees the new bits

   // write only the bits whose mask is set, all others keep their value
   always_ff @(posedge clk_i)
   begin
      if (wr_i.w_v)
      begin
         for (int i = 0; i < `FS_WORD_WIDTH; i++)
         begin
            if (wr_i.mask[i])
            begin
               mem[wr_i.addr][i] <= wr_i.data[i];
            end
         end
      end
   end

   // the address goes unknown on idle cycles
   // otherwise the output would quietly follow later writes to the last
   // word read, which a hard RAM macro would never do
   always_ff @(posedge clk_i)
   begin
      if (rd_i.r_v)
      begin
         r_addr_r <= rd_i.addr;
      end
      else
      begin
         r_addr_r <= 'X;
      end
   end

   // read mux after the edge
   assign r_data_o = mem[r_addr_r];

   // same-address read and write in one cycle is undefined for a hard RAM
   // the single command stream should make it impossible
   assert property (@(posedge clk_i) disable iff (reset_i)
                    !(wr_i.w_v && rd_i.r_v && (wr_i.addr == rd_i.addr)))
   else
      $error("read and write collide at address %0h", rd_i.addr);

endmodule

`default_nettype wire

//--- source/field_read_unit.sv
// read unit of the field store, drives the RAM read port and returns the field aligned to bit 0
`timescale 1ns/1ns
`include "field_store_macros.svh"
`default_nettype none

module field_read_unit
   import field_store_pkg::*;
(
   input  wire logic                      clk_i,
   input  wire logic                      reset_i,
   input  wire fs_rd_req_t                rd_req_i,
   output      fs_ram_rd_t                ram_rd_o,
   input  wire logic [`FS_WORD_WIDTH-1:0] ram_data_i,
   output      logic                      rd_v_o,
   output      logic [`FS_WORD_WIDTH-1:0] rd_field_o
);

   // first stage, the field shape waits here while the RAM reads the word
   logic                        req_v_q;
   logic [`FS_OFFSET_WIDTH-1:0] offset_q;
   logic [`FS_LEN_WIDTH-1:0]    len_m1_q;

   // second stage input
   logic [`FS_WORD_WIDTH-1:0]   low_ones;
   logic [`FS_WORD_WIDTH-1:0]   field_d;

   // the request goes straight to the RAM, which latches the address on this edge
   assign ram_rd_o.r_v  = rd_req_i.v;
   assign ram_rd_o.addr = rd_req_i.addr;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         req_v_q <= 1'b0;
      end
      else
      begin
         req_v_q <= rd_req_i.v;
      end
   end

   // shape registers load only with a request
   always_ff @(posedge clk_i)
   begin
      if (rd_req_i.v)
      begin
         offset_q <= rd_req_i.offset;
         len_m1_q <= rd_req_i.len_m1;
      end
   end

   // len_m1+1 ones at the bottom, same construction as the write mask
   assign low_ones = {`FS_WORD_WIDTH{1'b1}}
                     >> (`FS_LEN_WIDTH'(`FS_WORD_WIDTH - 1) - len_m1_q);

   // bring the field down to bit 0 and clear the neighbours above it
   // bits past bit 31 were never stored, the right shift fills them with zeros
   assign field_d = (ram_data_i >> offset_q) & low_ones;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_v_o <= 1'b0;
      end
      else
      begin
         rd_v_o <= req_v_q;
      end
   end

   // field holds between responses, ram data is unknown on idle cycles
   always_ff @(posedge clk_i)
   begin
      if (req_v_q)
      begin
         rd_field_o <= field_d;
      end
   end

   // the response was cut to the length that was in stage one a cycle earlier
   assert property (@(posedge clk_i) disable iff (reset_i)
                    rd_v_o |-> ((rd_field_o
                                 & ~({`FS_WORD_WIDTH{1'b1}}
                                     >> (`FS_LEN_WIDTH'(`FS_WORD_WIDTH - 1)
                                         - $past(len_m1_q)))) == '0))
   else
      $error("read field %0h has bits above its length", rd_field_o);

endmodule

`default_nettype wire

//--- source/field_store_top.sv
// top level of the bit-field register store, one command per clock in and aligned read fields out
`timescale 1ns/1ns
`include "field_store_macros.svh"
`default_nettype none

module field_store_top
   import field_store_pkg::*;
(
   input  wire logic                      clk_i,
   input  wire logic                      reset_i,
   input  wire logic                      cmd_v_i,
   input  wire fs_cmd_u                   cmd_i,
   output      logic                      rd_v_o,
   output      logic [`FS_WORD_WIDTH-1:0] rd_field_o
);

   // masked write from the decoder into the RAM
   fs_wr_port_t               wr;

   // read request from the decoder into the read unit
   fs_rd_req_t                rd_req;

   // RAM read port and the word it returns
   fs_ram_rd_t                ram_rd;
   logic [`FS_WORD_WIDTH-1:0] ram_data;

   // producer, splits the command stream into writes and read requests
   field_cmd_decoder u_decoder
   (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .cmd_v_i  (cmd_v_i),
      .cmd_i    (cmd_i),
      .wr_o     (wr),
      .rd_req_o (rd_req)
   );

   // buffer, the 16 by 32 masked-write RAM
   field_store_ram u_ram
   (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .wr_i     (wr),
      .rd_i     (ram_rd),
      .r_data_o (ram_data)
   );

   // consumer, reads the word and hands back the field two edges after the command
   field_read_unit u_read_unit
   (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .rd_req_i   (rd_req),
      .ram_rd_o   (ram_rd),
      .ram_data_i (ram_data),
      .rd_v_o     (rd_v_o),
      .rd_field_o (rd_field_o)
   );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// clock and reset source for the field store testbench, 20 ns period with reset held for 4 edges
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
   output logic clk_o,
   output logic reset_o
);

   // free running clock, first rising edge at 10 ns
   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #10 clk_o = ~clk_o;
      end
   end

   // reset is seen by 4 rising edges and drops just after the last one
   initial
   begin
      reset_o = 1'b1;
      repeat (4) @(posedge clk_o);
      #1 reset_o = 1'b0;
   end

endmodule

`default_nettype wire

//--- verif/field_store_tb.sv
// directed testbench that checks field store reads against a bit-level reference memory
`timescale 1ns/1ns
`include "field_store_macros.svh"
`default_nettype none

module field_store_tb
   import field_store_pkg::*;
;

   logic                      clk;
   logic                      reset;
   logic                      cmd_v;
   fs_cmd_u                   cmd;
   logic                      rd_v;
   logic [`FS_WORD_WIDTH-1:0] rd_field;

   // reference memory that is updated one bit at a time
   logic [`FS_WORD_WIDTH-1:0] model [`FS_DEPTH];

   tb_clock_gen u_clock_gen
   (
      .clk_o   (clk),
      .reset_o (reset)
   );

   field_store_top i_dut
   (
      .clk_i      (clk),
      .reset_i    (reset),
      .cmd_v_i    (cmd_v),
      .cmd_i      (cmd),
      .rd_v_o     (rd_v),
      .rd_field_o (rd_field)
   );

   task automatic stop_run();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         stop_run();
      end
   endtask

   // all driving and sampling happens 2 ns after a rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   // a bit belongs to the field if it lies in offset..offset+len_m1 and below 32
   function automatic logic [31:0] model_field(input logic [31:0] word, input int offset,
                                                input int len_m1);
      logic [31:0] result;
      result = '0;
      for (int i = 0; i <= len_m1; i++)
      begin
         if (i + offset < `FS_WORD_WIDTH)
         begin
            result[i] = word[i + offset];
         end
      end
      return result;
   endfunction

   function automatic fs_cmd_u make_cmd(input fs_op_e op, input int addr, input int offset,
                                        input int len_m1, input logic [31:0] value);
      fs_cmd_u c;
      c.wr.op     = op;
      c.wr.addr   = addr[`FS_ADDR_WIDTH-1:0];
      c.wr.offset = offset[`FS_OFFSET_WIDTH-1:0];
      c.wr.len_m1 = len_m1[`FS_LEN_WIDTH-1:0];
      // reads leave the low word of the read view at zero
      c.wr.value  = (op == FS_OP_WRITE) ? value : '0;
      return c;
   endfunction

   // the command is taken at the next edge and the strobe drops right after it
   task automatic issue_cmd(input fs_cmd_u c);
      cmd_v = 1'b1;
      cmd   = c;
      next_cycle();
      cmd_v = 1'b0;
   endtask

   task automatic write_field(input int addr, input int offset, input int len_m1,
                              input logic [31:0] value);
      issue_cmd(make_cmd(FS_OP_WRITE, addr, offset, len_m1, value));
      for (int i = 0; i <= len_m1; i++)
      begin
         if (i + offset < `FS_WORD_WIDTH)
         begin
            model[addr][i + offset] = value[i];
         end
      end
   endtask

   // one read whose pulse is due one cycle after the command edge and lasts one cycle
   task automatic read_check(input string name, input int addr, input int offset,
                             input int len_m1);
      int waited;
      issue_cmd(make_cmd(FS_OP_READ, addr, offset, len_m1, '0));
      waited = 0;
      while (rd_v !== 1'b1)
      begin
         if (waited >= 10)
         begin
            $display("read response never came in %s", name);
            stop_run();
         end
         next_cycle();
         waited++;
      end
      check_value(name, 32'd1, waited);
      check_value(name, model_field(model[addr], offset, len_m1), rd_field);
      next_cycle();
      check_value(name, 32'd0, {31'd0, rd_v});
   endtask

   task automatic test_reset_idle();
      int cycles;
      cycles = 0;
      next_cycle();
      while (reset === 1'b1)
      begin
         check_value("test_reset_idle", 32'd0, {31'd0, rd_v});
         if (cycles >= 10)
         begin
            $display("reset never went low in test_reset_idle");
            stop_run();
         end
         next_cycle();
         cycles++;
      end
      repeat (5)
      begin
         check_value("test_reset_idle", 32'd0, {31'd0, rd_v});
         next_cycle();
      end
   endtask

   task automatic test_full_words();
      for (int a = 0; a < `FS_DEPTH; a++)
      begin
         write_field(a, 0, 31, $urandom);
      end
      for (int a = 0; a < `FS_DEPTH; a++)
      begin
         read_check("test_full_words", a, 0, 31);
      end
   endtask

   // every word holds data from the full word test, so untouched bits are known
   task automatic test_masked_fields();
      int addr;
      int offset;
      int len_m1;
      for (int n = 0; n < 16; n++)
      begin
         addr   = $urandom % `FS_DEPTH;
         offset = $urandom % 32;
         len_m1 = $urandom % 32;
         write_field(addr, offset, len_m1, $urandom);
         read_check("test_masked_fields", addr, 0, 31);
         read_check("test_masked_fields", addr, offset, len_m1);
      end
   endtask

   task automatic test_back_to_back();
      write_field(5, 8, 11, 32'h0000_0abc);
      read_check("test_back_to_back", 5, 8, 11);
      write_field(12, 28, 7, 32'h0000_00f5);
      read_check("test_back_to_back", 12, 28, 7);
   endtask

   // commands and responses overlap, so both run in one cycle loop
   task automatic test_streamed_reads();
      logic [31:0] expected [$];
      int          sent;
      int          got;
      int          cycles;
      int          addr;
      int          offset;
      int          len_m1;
      sent   = 0;
      got    = 0;
      cycles = 0;
      while (got < 8)
      begin
         if (sent < 8)
         begin
            addr   = $urandom % `FS_DEPTH;
            offset = $urandom % 32;
            len_m1 = $urandom % 32;
            cmd_v  = 1'b1;
            cmd    = make_cmd(FS_OP_READ, addr, offset, len_m1, '0);
            expected.push_back(model_field(model[addr], offset, len_m1));
            sent++;
         end
         else
         begin
            cmd_v = 1'b0;
         end
         next_cycle();
         cycles++;
         if (rd_v === 1'b1)
         begin
            // each response is due two edges after its own command
            check_value("test_streamed_reads", got + 2, cycles);
            check_value("test_streamed_reads", expected.pop_front(), rd_field);
            got++;
         end
         if (cycles > 18)
         begin
            $display("read response never came in test_streamed_reads");
            stop_run();
         end
      end
      cmd_v = 1'b0;
      next_cycle();
      // an extra pulse here would mean more responses than reads
      check_value("test_streamed_reads", 32'd0, {31'd0, rd_v});
   endtask

   initial
   begin
      cmd_v = 1'b0;
      cmd   = '0;
      void'($urandom(32'h12c120f6));
      test_reset_idle();
      test_full_words();
      test_masked_fields();
      test_back_to_back();
      test_streamed_reads();
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/field_store_pkg.sv
source/field_cmd_decoder.sv
source/field_store_ram.sv
source/field_read_unit.sv
source/field_store_top.sv
verif/tb_clock_gen.sv
verif/field_store_tb.sv

//--- Bender.yml
package:
  name: field_store

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/field_store_pkg.sv
      - source/field_cmd_decoder.sv
      - source/field_store_ram.sv
      - source/field_read_unit.sv
      - source/field_store_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verif/tb_clock_gen.sv
      - verif/field_store_tb.sv
